/* vlog.f */
hdl/hdcpu_pkg.sv
hdl/ctrl_if.sv
hdl/console_ctrl.sv
hdl/instr_decode.sv
hdl/mode_sequencer.sv
hdl/hdcpu_top.sv
+incdir+verification
verification/hdcpu_tb.sv

/* verification/hdcpu_model.svh */
`ifndef HDCPU_MODEL_SVH
`define HDCPU_MODEL_SVH

// One field per control line, phase requests in the two low bits
typedef struct packed {
    logic ldc, ldz, cin, m, abus, drw, pcinc, lpc, lar, pcadd;
    logic arinc, selctl, memw, stop, lir, sbus, mbus, short_beat, long_beat;
    hdcpu_pkg::alu_func_t s;
    hdcpu_pkg::reg_sel_t  sel;
    logic st0_set, st0_clr;
} ctrl_t;

function automatic ctrl_t console_model(hdcpu_pkg::sw_mode_t sw, hdcpu_pkg::beat_t w,
                                        logic act);
    ctrl_t e;
    logic [1:0] dest;
    e = '0;
    dest = {act, !w[0]};
    if ((sw == hdcpu_pkg::MODE_WR_MEM || sw == hdcpu_pkg::MODE_RD_MEM) && w[0]) begin
        // AR from switches first, then memory access with AR increment
        e.lar = !act;
        e.arinc = act;
        e.memw = act && sw == hdcpu_pkg::MODE_WR_MEM;
        e.mbus = act && sw == hdcpu_pkg::MODE_RD_MEM;
        e.sbus = !e.mbus;
        {e.selctl, e.short_beat, e.stop, e.st0_set} = 4'b1111;
    end else if (sw == hdcpu_pkg::MODE_RD_REG && (w[0] || w[1])) begin
        e.sel = w[0] ? hdcpu_pkg::SEL_R0_R1 : hdcpu_pkg::SEL_R2_R3;
        {e.selctl, e.stop} = 2'b11;
    end else if (sw == hdcpu_pkg::MODE_WR_REG && (w[0] || w[1])) begin
        // Destination R0 then R1 in setup, R2 then R3 once active
        e.sel = {dest, dest - 2'd1};
        {e.drw, e.sbus, e.selctl, e.stop} = 4'b1111;
        e.st0_set = !w[0] && !act;
        e.st0_clr = !w[0] && act;
    end
    return e;
endfunction

function automatic ctrl_t exec_model(hdcpu_pkg::beat_t w, hdcpu_pkg::opcode_t ir,
                                     logic c, logic z, logic act);
    ctrl_t e;
    logic w2;
    logic w3;
    e = '0;
    w2 = w[1] && !w[0];
    w3 = w[2] && !w[1] && !w[0];
    if (!act) begin
        // Switches into R3 at W1, R3 into the PC at W2
        {e.drw, e.sbus, e.stop} = {3{w[0]}};
        {e.abus, e.lpc, e.m, e.st0_set} = {4{w2}};
        e.selctl = w[0] || w2;
        e.s = e.selctl ? hdcpu_pkg::ALU_PASS_B : '0;
        e.sel = e.selctl ? hdcpu_pkg::SEL_R3_R3 : '0;
    end else if (w[0]) begin
        {e.lir, e.pcinc} = 2'b11;
    end else begin
        case (ir)
            hdcpu_pkg::OP_ADD, hdcpu_pkg::OP_SUB, hdcpu_pkg::OP_INC: begin
                {e.abus, e.drw, e.ldc, e.ldz} = {4{w2}};
                e.cin = w2 && ir == hdcpu_pkg::OP_ADD;
                e.s = !w2 ? '0 : ir == hdcpu_pkg::OP_ADD ? hdcpu_pkg::ALU_ADD :
                      ir == hdcpu_pkg::OP_SUB ? hdcpu_pkg::ALU_SUB : hdcpu_pkg::ALU_INC;
            end
            hdcpu_pkg::OP_AND, hdcpu_pkg::OP_OR, hdcpu_pkg::OP_XOR: begin
                {e.abus, e.drw, e.ldz, e.m} = {4{w2}};
                e.s = !w2 ? '0 : ir == hdcpu_pkg::OP_AND ? hdcpu_pkg::ALU_AND :
                      ir == hdcpu_pkg::OP_OR ? hdcpu_pkg::ALU_OR : hdcpu_pkg::ALU_SUB;
            end
            hdcpu_pkg::OP_LD, hdcpu_pkg::OP_ST: begin
                // Long W2 loads AR, data moves at W3
                {e.lar, e.long_beat} = {2{w2}};
                {e.drw, e.mbus} = {2{w3 && ir == hdcpu_pkg::OP_LD}};
                e.memw = w3 && ir == hdcpu_pkg::OP_ST;
                e.abus = w2 || e.memw;
                e.m = e.abus;
                e.s = (w2 && ir == hdcpu_pkg::OP_ST) ? hdcpu_pkg::ALU_PASS_A :
                      e.abus ? hdcpu_pkg::ALU_PASS_B : '0;
            end
            hdcpu_pkg::OP_JC, hdcpu_pkg::OP_JZ: begin
                e.pcadd = w2 && (ir == hdcpu_pkg::OP_JC ? c : z);
            end
            hdcpu_pkg::OP_JMP, hdcpu_pkg::OP_OUT: begin
                {e.abus, e.m} = {2{w2}};
                e.lpc = w2 && ir == hdcpu_pkg::OP_JMP;
                e.s = !w2 ? '0 : e.lpc ? hdcpu_pkg::ALU_PASS_A : hdcpu_pkg::ALU_PASS_B;
            end
            hdcpu_pkg::OP_STP: begin
                e.stop = w2;
            end
            default: begin
            end
        endcase
    end
    return e;
endfunction

// All zero in reset and for unused modes
function automatic ctrl_t expected_ctrl(logic rst_n, hdcpu_pkg::sw_mode_t sw,
                                        hdcpu_pkg::opcode_t ir, hdcpu_pkg::beat_t w,
                                        logic c, logic z, logic act);
    return !rst_n ? ctrl_t'('0) : (sw == hdcpu_pkg::MODE_EXEC) ? exec_model(w, ir, c, z, act)
                                                               : console_model(sw, w, act);
endfunction

function automatic logic next_phase(logic act, ctrl_t e);
    return e.st0_set ? 1'b1 : (e.st0_clr ? 1'b0 : act);
endfunction

`endif

/* verification/hdcpu_tb.sv */
`timescale 1ns/10ps

module hdcpu_tb;

    localparam int PERIOD = 40;
    localparam int RESET_CYCLES = 5;
    localparam int DIRECTED_BEATS = 80;
    localparam int RANDOM_BEATS = 2000;
    localparam logic [31:0] SEED = 32'h20c553eb;

    `include "hdcpu_model.svh"

    logic t3, arst_n, c, z;
    hdcpu_pkg::sw_mode_t sw;
    hdcpu_pkg::opcode_t ir;
    hdcpu_pkg::beat_t w;
    logic ldc, ldz, cin, m, abus, drw, pcinc, lpc, lar, pcadd;
    logic arinc, selctl, memw, stop, lir, sbus, mbus, short_beat, long_beat;
    hdcpu_pkg::alu_func_t s;
    hdcpu_pkg::reg_sel_t sel;
    logic model_phase = 1'b0;
    int errors = 0;
    int test_errors = 0;
    int checks = 0;
    int tests = 0;
    ctrl_t got;
    string names [19] = '{"ldc", "ldz", "cin", "m", "abus", "drw", "pcinc", "lpc", "lar",
                          "pcadd", "arinc", "selctl", "memw", "stop", "lir", "sbus", "mbus",
                          "short_beat", "long_beat"};

    // Same field order as ctrl_t, phase requests are internal
    assign got = {ldc, ldz, cin, m, abus, drw, pcinc, lpc, lar, pcadd, arinc, selctl,
                  memw, stop, lir, sbus, mbus, short_beat, long_beat, s, sel, 2'b00};

    hdcpu_top hdcpu_top_inst (.*);

    initial begin
        t3 = 1'b0;
        forever #(PERIOD / 2) t3 = ~t3;
    end

    always @(posedge t3 or negedge arst_n) begin
        if (!arst_n) begin
            model_phase <= 1'b0;
        end else begin
            model_phase <= next_phase(model_phase,
                                      expected_ctrl(1'b1, sw, ir, w, c, z, model_phase));
        end
    end

    initial begin
        #((RESET_CYCLES + DIRECTED_BEATS + RANDOM_BEATS + 50) * PERIOD);
        $display("Watchdog expired before the tests completed");
        $display("Errors found");
        $finish;
    end

    task automatic check_value(string name, logic [3:0] exp, logic [3:0] act);
        checks++;
        if (exp !== act) begin
            $display("** Error at %0t: %s expected %h, actual %h", $time, name, exp, act);
            errors++;
            test_errors++;
        end
    endtask

    // Inputs change on the falling edge, outputs checked a quarter period later
    task automatic apply_beat(hdcpu_pkg::sw_mode_t sw_v, hdcpu_pkg::opcode_t ir_v,
                              hdcpu_pkg::beat_t w_v, logic c_v, logic z_v);
        ctrl_t exp;
        int i;
        @(negedge t3);
        {sw, ir, w, c, z} = {sw_v, ir_v, w_v, c_v, z_v};
        #(PERIOD / 4);
        exp = expected_ctrl(arst_n, sw, ir, w, c, z, model_phase);
        for (i = 0; i < 19; i++) begin
            check_value(names[i], exp[28 - i], got[28 - i]);
        end
        check_value("s", exp.s, s);
        check_value("sel", exp.sel, sel);
    endtask

    task automatic report_test(string title);
        $display("Test %s: %0d errors", title, test_errors);
        test_errors = 0;
        tests++;
    endtask

    initial begin
        int op;
        void'($urandom(SEED));
        arst_n = 1'b0;
        {sw, ir, w, c, z} = '0;
        repeat (RESET_CYCLES - 1) begin
            apply_beat(hdcpu_pkg::MODE_EXEC, hdcpu_pkg::OP_ADD, 3'b011, 1, 1);
        end
        @(negedge t3);
        arst_n = 1'b1;
        apply_beat(hdcpu_pkg::MODE_EXEC, '0, 3'b001, 0, 0);
        report_test("reset");

        repeat (4) apply_beat(hdcpu_pkg::MODE_WR_MEM, '0, 3'b001, 0, 0);
        // Back to setup before the read pass
        apply_beat(hdcpu_pkg::MODE_WR_REG, '0, 3'b010, 0, 0);
        repeat (4) apply_beat(hdcpu_pkg::MODE_RD_MEM, '0, 3'b001, 0, 0);
        report_test("memory");

        apply_beat(hdcpu_pkg::MODE_RD_REG, '0, 3'b001, 0, 0);
        apply_beat(hdcpu_pkg::MODE_RD_REG, '0, 3'b010, 0, 0);
        repeat (3) begin
            apply_beat(hdcpu_pkg::MODE_WR_REG, '0, 3'b001, 0, 0);
            apply_beat(hdcpu_pkg::MODE_WR_REG, '0, 3'b010, 0, 0);
        end
        report_test("registers");

        apply_beat(hdcpu_pkg::MODE_EXEC, '0, 3'b001, 0, 0);
        apply_beat(hdcpu_pkg::MODE_EXEC, '0, 3'b010, 0, 0);
        for (op = 0; op < 16; op++) begin
            apply_beat(hdcpu_pkg::MODE_EXEC, op, 3'b001, 0, 0);
            apply_beat(hdcpu_pkg::MODE_EXEC, op, 3'b010, op[0], op[1]);
            apply_beat(hdcpu_pkg::MODE_EXEC, op, 3'b100, 0, 0);
        end
        report_test("execute");

        repeat (RANDOM_BEATS) begin
            apply_beat($urandom(), $urandom(), $urandom(), $urandom(), $urandom());
        end
        report_test("random");

        $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

/* hdl/hdcpu_top.sv */
`timescale 1ns/10ps

module hdcpu_top (
    input  logic                  t3,
    input  logic                  arst_n,
    input  logic                  c,
    input  logic                  z,
    input  hdcpu_pkg::sw_mode_t   sw,
    input  hdcpu_pkg::opcode_t    ir,
    input  hdcpu_pkg::beat_t      w,
    output logic                  ldc,
    output logic                  ldz,
    output logic                  cin,
    output logic                  m,
    output logic                  abus,
    output logic                  drw,
    output logic                  pcinc,
    output logic                  lpc,
    output logic                  lar,
    output logic                  pcadd,
    output logic                  arinc,
    output logic                  selctl,
    output logic                  memw,
    output logic                  stop,
    output logic                  lir,
    output logic                  sbus,
    output logic                  mbus,
    output logic                  short_beat,
    output logic                  long_beat,
    output hdcpu_pkg::alu_func_t  s,
    output hdcpu_pkg::reg_sel_t   sel
);

    hdcpu_pkg::op_phase_e phase;

    ctrl_if console_bus ();
    ctrl_if exec_bus ();

    console_ctrl console_ctrl_inst (
        .sw    (sw),
        .w     (w),
        .phase (phase),
        .ctl   (console_bus.source)
    );

    instr_decode instr_decode_inst (
        .w     (w),
        .ir    (ir),
        .c     (c),
        .z     (z),
        .phase (phase),
        .ctl   (exec_bus.source)
    );

    mode_sequencer mode_sequencer_inst (
        .t3         (t3),
        .arst_n     (arst_n),
        .sw         (sw),
        .console    (console_bus.sink),
        .exec       (exec_bus.sink),
        .phase      (phase),
        .ldc        (ldc),
        .ldz        (ldz),
        .cin        (cin),
        .m          (m),
        .abus       (abus),
        .drw        (drw),
        .pcinc      (pcinc),
        .lpc        (lpc),
        .lar        (lar),
        .pcadd      (pcadd),
        .arinc      (arinc),
        .selctl     (selctl),
        .memw       (memw),
        .stop       (stop),
        .lir        (lir),
        .sbus       (sbus),
        .mbus       (mbus),
        .short_beat (short_beat),
        .long_beat  (long_beat),
        .s          (s),
        .sel        (sel)
    );

endmodule

/* hdl/mode_sequencer.sv */
`timescale 1ns/10ps

module mode_sequencer (
    input  logic                  t3,
    input  logic                  arst_n,
    input  hdcpu_pkg::sw_mode_t   sw,
    ctrl_if.sink                  console,
    ctrl_if.sink                  exec,
    output hdcpu_pkg::op_phase_e  phase,
    output logic                  ldc,
    output logic                  ldz,
    output logic                  cin,
    output logic                  m,
    output logic                  abus,
    output logic                  drw,
    output logic                  pcinc,
    output logic                  lpc,
    output logic                  lar,
    output logic                  pcadd,
    output logic                  arinc,
    output logic                  selctl,
    output logic                  memw,
    output logic                  stop,
    output logic                  lir,
    output logic                  sbus,
    output logic                  mbus,
    output logic                  short_beat,
    output logic                  long_beat,
    output hdcpu_pkg::alu_func_t  s,
    output hdcpu_pkg::reg_sel_t   sel
);

    logic use_con;
    logic use_exe;
    logic st0_set;
    logic st0_clr;

    // Both zero outside reset release or for an unused mode
    assign use_exe = arst_n && (sw == hdcpu_pkg::MODE_EXEC);
    assign use_con = arst_n && (sw == hdcpu_pkg::MODE_WR_MEM || sw == hdcpu_pkg::MODE_RD_MEM ||
                                sw == hdcpu_pkg::MODE_RD_REG || sw == hdcpu_pkg::MODE_WR_REG);

    assign ldc        = (use_exe & exec.ldc) | (use_con & console.ldc);
    assign ldz        = (use_exe & exec.ldz) | (use_con & console.ldz);
    assign cin        = (use_exe & exec.cin) | (use_con & console.cin);
    assign m          = (use_exe & exec.m) | (use_con & console.m);
    assign abus       = (use_exe & exec.abus) | (use_con & console.abus);
    assign drw        = (use_exe & exec.drw) | (use_con & console.drw);
    assign pcinc      = (use_exe & exec.pcinc) | (use_con & console.pcinc);
    assign lpc        = (use_exe & exec.lpc) | (use_con & console.lpc);
    assign lar        = (use_exe & exec.lar) | (use_con & console.lar);
    assign pcadd      = (use_exe & exec.pcadd) | (use_con & console.pcadd);
    assign arinc      = (use_exe & exec.arinc) | (use_con & console.arinc);
    assign selctl     = (use_exe & exec.selctl) | (use_con & console.selctl);
    assign memw       = (use_exe & exec.memw) | (use_con & console.memw);
    assign stop       = (use_exe & exec.stop) | (use_con & console.stop);
    assign lir        = (use_exe & exec.lir) | (use_con & console.lir);
    assign sbus       = (use_exe & exec.sbus) | (use_con & console.sbus);
    assign mbus       = (use_exe & exec.mbus) | (use_con & console.mbus);
    assign short_beat = (use_exe & exec.short_beat) | (use_con & console.short_beat);
    assign long_beat  = (use_exe & exec.long_beat) | (use_con & console.long_beat);
    assign s          = ({4{use_exe}} & exec.s) | ({4{use_con}} & console.s);
    assign sel        = ({4{use_exe}} & exec.sel) | ({4{use_con}} & console.sel);
    assign st0_set    = (use_exe & exec.st0_set) | (use_con & console.st0_set);
    assign st0_clr    = (use_exe & exec.st0_clr) | (use_con & console.st0_clr);

    // Set wins over clear
    always_ff @(posedge t3 or negedge arst_n) begin
        if (!arst_n) begin
            phase <= hdcpu_pkg::PHASE_SETUP;
        end else if (st0_set) begin
            phase <= hdcpu_pkg::PHASE_ACTIVE;
        end else if (st0_clr) begin
            phase <= hdcpu_pkg::PHASE_SETUP;
        end
    end

    // One bus driver per beat across both decoders
    assert property (@(posedge t3) disable iff (!arst_n) $onehot0({abus, sbus, mbus}));

    assert property (@(posedge t3) disable iff (!arst_n) !(st0_set && st0_clr));

endmodule

/* hdl/instr_decode.sv */
`timescale 1ns/10ps

module instr_decode (
    input  hdcpu_pkg::beat_t     w,
    input  hdcpu_pkg::opcode_t   ir,
    input  logic                 c,
    input  logic                 z,
    input  hdcpu_pkg::op_phase_e phase,
    ctrl_if.source               ctl
);

    logic jump_taken;

    // Conditional branch on the flag of the opcode
    assign jump_taken = (ir == hdcpu_pkg::OP_JC && c) || (ir == hdcpu_pkg::OP_JZ && z);

    always_comb begin
        ctl.ldc        = 1'b0;
        ctl.ldz        = 1'b0;
        ctl.cin        = 1'b0;
        ctl.m          = 1'b0;
        ctl.abus       = 1'b0;
        ctl.drw        = 1'b0;
        ctl.pcinc      = 1'b0;
        ctl.lpc        = 1'b0;
        ctl.lar        = 1'b0;
        ctl.pcadd      = 1'b0;
        ctl.arinc      = 1'b0;
        ctl.selctl     = 1'b0;
        ctl.memw       = 1'b0;
        ctl.stop       = 1'b0;
        ctl.lir        = 1'b0;
        ctl.sbus       = 1'b0;
        ctl.mbus       = 1'b0;
        ctl.short_beat = 1'b0;
        ctl.long_beat  = 1'b0;
        ctl.s          = '0;
        ctl.sel        = '0;
        ctl.st0_set    = 1'b0;
        ctl.st0_clr    = 1'b0;

        if (phase == hdcpu_pkg::PHASE_SETUP) begin
            // Start-up: switches to R3, then R3 to PC
            if (w[0]) begin
                ctl.drw    = 1'b1;
                ctl.s      = hdcpu_pkg::ALU_PASS_B;
                ctl.sbus   = 1'b1;
                ctl.sel    = hdcpu_pkg::SEL_R3_R3;
                ctl.selctl = 1'b1;
                ctl.stop   = 1'b1;
            end else if (w[1]) begin
                ctl.abus    = 1'b1;
                ctl.lpc     = 1'b1;
                ctl.m       = 1'b1;
                ctl.s       = hdcpu_pkg::ALU_PASS_B;
                ctl.sel     = hdcpu_pkg::SEL_R3_R3;
                ctl.selctl  = 1'b1;
                ctl.st0_set = 1'b1;
            end
        end else if (w[0]) begin
            // Fetch
            ctl.lir   = 1'b1;
            ctl.pcinc = 1'b1;
        end else begin
            case (ir)
                hdcpu_pkg::OP_ADD, hdcpu_pkg::OP_SUB: begin
                    if (w[1]) begin
                        ctl.abus = 1'b1;
                        ctl.cin  = (ir == hdcpu_pkg::OP_ADD);
                        ctl.drw  = 1'b1;
                        ctl.ldc  = 1'b1;
                        ctl.ldz  = 1'b1;
                        ctl.s    = (ir == hdcpu_pkg::OP_ADD) ? hdcpu_pkg::ALU_ADD
                                                             : hdcpu_pkg::ALU_SUB;
                    end
                end
                hdcpu_pkg::OP_AND, hdcpu_pkg::OP_OR, hdcpu_pkg::OP_XOR: begin
                    if (w[1]) begin
                        ctl.abus = 1'b1;
                        ctl.drw  = 1'b1;
                        ctl.ldz  = 1'b1;
                        ctl.m    = 1'b1;
                        if (ir == hdcpu_pkg::OP_AND) begin
                            ctl.s = hdcpu_pkg::ALU_AND;
                        end else if (ir == hdcpu_pkg::OP_OR) begin
                            ctl.s = hdcpu_pkg::ALU_OR;
                        end else begin
                            ctl.s = hdcpu_pkg::ALU_SUB;
                        end
                    end
                end
                hdcpu_pkg::OP_INC: begin
                    if (w[1]) begin
                        ctl.abus = 1'b1;
                        ctl.drw  = 1'b1;
                        ctl.ldc  = 1'b1;
                        ctl.ldz  = 1'b1;
                        ctl.s    = hdcpu_pkg::ALU_INC;
                    end
                end
                hdcpu_pkg::OP_LD: begin
                    // Address to AR, then memory to register
                    if (w[1]) begin
                        ctl.abus      = 1'b1;
                        ctl.lar       = 1'b1;
                        ctl.long_beat = 1'b1;
                        ctl.m         = 1'b1;
                        ctl.s         = hdcpu_pkg::ALU_PASS_B;
                    end else if (w[2]) begin
                        ctl.drw  = 1'b1;
                        ctl.mbus = 1'b1;
                    end
                end
                hdcpu_pkg::OP_ST: begin
                    if (w[1]) begin
                        ctl.abus      = 1'b1;
                        ctl.lar       = 1'b1;
                        ctl.long_beat = 1'b1;
                        ctl.m         = 1'b1;
                        ctl.s         = hdcpu_pkg::ALU_PASS_A;
                    end else if (w[2]) begin
                        ctl.abus = 1'b1;
                        ctl.m    = 1'b1;
                        ctl.memw = 1'b1;
                        ctl.s    = hdcpu_pkg::ALU_PASS_B;
                    end
                end
                hdcpu_pkg::OP_JC, hdcpu_pkg::OP_JZ: begin
                    ctl.pcadd = w[1] && jump_taken;
                end
                hdcpu_pkg::OP_JMP: begin
                    if (w[1]) begin
                        ctl.abus = 1'b1;
                        ctl.lpc  = 1'b1;
                        ctl.m    = 1'b1;
                        ctl.s    = hdcpu_pkg::ALU_PASS_A;
                    end
                end
                hdcpu_pkg::OP_OUT: begin
                    if (w[1]) begin
                        ctl.abus = 1'b1;
                        ctl.m    = 1'b1;
                        ctl.s    = hdcpu_pkg::ALU_PASS_B;
                    end
                end
                hdcpu_pkg::OP_STP: begin
                    ctl.stop = w[1];
                end
                default: begin
                end
            endcase
        end
    end

endmodule

/* hdl/console_ctrl.sv */
`timescale 1ns/10ps

module console_ctrl (
    input  hdcpu_pkg::sw_mode_t  sw,
    input  hdcpu_pkg::beat_t     w,
    input  hdcpu_pkg::op_phase_e phase,
    ctrl_if.source               ctl
);

    logic active;

    assign active = (phase == hdcpu_pkg::PHASE_ACTIVE);

    always_comb begin
        ctl.ldc        = 1'b0;
        ctl.ldz        = 1'b0;
        ctl.cin        = 1'b0;
        ctl.m          = 1'b0;
        ctl.abus       = 1'b0;
        ctl.drw        = 1'b0;
        ctl.pcinc      = 1'b0;
        ctl.lpc        = 1'b0;
        ctl.lar        = 1'b0;
        ctl.pcadd      = 1'b0;
        ctl.arinc      = 1'b0;
        ctl.selctl     = 1'b0;
        ctl.memw       = 1'b0;
        ctl.stop       = 1'b0;
        ctl.lir        = 1'b0;
        ctl.sbus       = 1'b0;
        ctl.mbus       = 1'b0;
        ctl.short_beat = 1'b0;
        ctl.long_beat  = 1'b0;
        ctl.s          = '0;
        ctl.sel        = '0;
        ctl.st0_set    = 1'b0;
        ctl.st0_clr    = 1'b0;

        case (sw)
            hdcpu_pkg::MODE_WR_MEM: begin
                // First pass loads AR from the switches
                if (w[0]) begin
                    ctl.lar        = !active;
                    ctl.arinc      = active;
                    ctl.memw       = active;
                    ctl.sbus       = 1'b1;
                    ctl.selctl     = 1'b1;
                    ctl.short_beat = 1'b1;
                    ctl.stop       = 1'b1;
                    ctl.st0_set    = 1'b1;
                end
            end
            hdcpu_pkg::MODE_RD_MEM: begin
                if (w[0]) begin
                    ctl.lar        = !active;
                    ctl.arinc      = active;
                    ctl.sbus       = !active;
                    ctl.mbus       = active;
                    ctl.selctl     = 1'b1;
                    ctl.short_beat = 1'b1;
                    ctl.stop       = 1'b1;
                    ctl.st0_set    = 1'b1;
                end
            end
            hdcpu_pkg::MODE_RD_REG: begin
                if (w[0]) begin
                    ctl.sel    = hdcpu_pkg::SEL_R0_R1;
                    ctl.selctl = 1'b1;
                    ctl.stop   = 1'b1;
                end else if (w[1]) begin
                    ctl.sel    = hdcpu_pkg::SEL_R2_R3;
                    ctl.selctl = 1'b1;
                    ctl.stop   = 1'b1;
                end
            end
            hdcpu_pkg::MODE_WR_REG: begin
                // R0 and R1 in setup, R2 and R3 once active
                if (w[0]) begin
                    ctl.drw    = 1'b1;
                    ctl.sbus   = 1'b1;
                    ctl.sel    = {active, 1'b0, !active, 1'b1};
                    ctl.selctl = 1'b1;
                    ctl.stop   = 1'b1;
                end else if (w[1]) begin
                    ctl.drw     = 1'b1;
                    ctl.sbus    = 1'b1;
                    ctl.sel     = {active, 1'b1, active, 1'b0};
                    ctl.selctl  = 1'b1;
                    ctl.stop    = 1'b1;
                    ctl.st0_set = !active;
                    ctl.st0_clr = active;
                end
            end
            default: begin
            end
        endcase
    end

endmodule

/* hdl/ctrl_if.sv */
`timescale 1ns/10ps

interface ctrl_if;

    logic                  ldc;
    logic                  ldz;
    logic                  cin;
    logic                  m;
    logic                  abus;
    logic                  drw;
    logic                  pcinc;
    logic                  lpc;
    logic                  lar;
    logic                  pcadd;
    logic                  arinc;
    logic                  selctl;
    logic                  memw;
    logic                  stop;
    logic                  lir;
    logic                  sbus;
    logic                  mbus;
    logic                  short_beat;
    logic                  long_beat;
    hdcpu_pkg::alu_func_t  s;
    hdcpu_pkg::reg_sel_t   sel;
    // Phase requests to the sequencer
    logic                  st0_set;
    logic                  st0_clr;

    modport source (
        output ldc, ldz, cin, m, abus, drw, pcinc, lpc, lar, pcadd, arinc, selctl,
               memw, stop, lir, sbus, mbus, short_beat, long_beat, s, sel, st0_set, st0_clr
    );

    modport sink (
        input ldc, ldz, cin, m, abus, drw, pcinc, lpc, lar, pcadd, arinc, selctl,
              memw, stop, lir, sbus, mbus, short_beat, long_beat, s, sel, st0_set, st0_clr
    );

endinterface

/* hdl/hdcpu_pkg.sv */
package hdcpu_pkg;

    // Vector types with a fixed meaning
    typedef logic [2:0] sw_mode_t;
    typedef logic [3:0] opcode_t;
    // Bit 0 is W1, bit 1 is W2, bit 2 is W3
    typedef logic [2:0] beat_t;
    typedef logic [3:0] alu_func_t;
    // Two 2-bit register numbers
    typedef logic [3:0] reg_sel_t;

    // Address or PC loaded yet
    typedef enum logic {
        PHASE_SETUP  = 1'b0,
        PHASE_ACTIVE = 1'b1
    } op_phase_e;

    // Console switch modes
    localparam sw_mode_t MODE_EXEC   = 3'b000;
    localparam sw_mode_t MODE_WR_MEM = 3'b001;
    localparam sw_mode_t MODE_RD_MEM = 3'b010;
    localparam sw_mode_t MODE_RD_REG = 3'b011;
    localparam sw_mode_t MODE_WR_REG = 3'b100;

    localparam opcode_t OP_ADD = 4'b0001;
    localparam opcode_t OP_SUB = 4'b0010;
    localparam opcode_t OP_AND = 4'b0011;
    localparam opcode_t OP_INC = 4'b0100;
    localparam opcode_t OP_LD  = 4'b0101;
    localparam opcode_t OP_ST  = 4'b0110;
    localparam opcode_t OP_JC  = 4'b0111;
    localparam opcode_t OP_JZ  = 4'b1000;
    localparam opcode_t OP_JMP = 4'b1001;
    localparam opcode_t OP_OUT = 4'b1010;
    localparam opcode_t OP_OR  = 4'b1100;
    localparam opcode_t OP_XOR = 4'b1101;
    localparam opcode_t OP_STP = 4'b1110;

    localparam alu_func_t ALU_ADD    = 4'b1001;
    // Gives XOR when m is set
    localparam alu_func_t ALU_SUB    = 4'b0110;
    localparam alu_func_t ALU_AND    = 4'b1011;
    localparam alu_func_t ALU_OR     = 4'b1110;
    localparam alu_func_t ALU_PASS_B = 4'b1010;
    localparam alu_func_t ALU_PASS_A = 4'b1111;
    localparam alu_func_t ALU_INC    = 4'b0000;

    localparam reg_sel_t SEL_R3_R3 = 4'b1111;
    localparam reg_sel_t SEL_R0_R1 = 4'b0001;
    localparam reg_sel_t SEL_R2_R3 = 4'b1011;

endpackage
